// File: rtl/disp_pkg.sv
/* display timing package
   line and frame geometry, pixel strobe rate and the coordinate type */
`default_nettype none

package disp_pkg;

    typedef logic signed [15:0] coord_t;  // screen or framebuffer coordinate

    localparam int PIX_DIV = 4;  // clocks per pixel

    localparam coord_t H_ACTIVE = 16'sd80;
    localparam coord_t H_FRONT  = 16'sd4;
    localparam coord_t H_SYNC   = 16'sd8;
    localparam coord_t H_BACK   = 16'sd8;
    localparam coord_t H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 100 pixels

    localparam coord_t V_ACTIVE = 16'sd60;
    localparam coord_t V_FRONT  = 16'sd2;
    localparam coord_t V_SYNC   = 16'sd2;
    localparam coord_t V_BACK   = 16'sd4;
    localparam coord_t V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 68 lines

    localparam coord_t HS_START = H_ACTIVE + H_FRONT;
    localparam coord_t HS_END   = HS_START + H_SYNC;
    localparam coord_t VS_START = V_ACTIVE + V_FRONT;
    localparam coord_t VS_END   = VS_START + V_SYNC;

    localparam logic SYNC_ACTIVE = 1'b0;  // both syncs active low, as 640x480

endpackage

`default_nettype wire

// File: rtl/gfx_pkg.sv
/* graphics package
   colour types, 16-entry palette, framebuffer geometry and the fixed scene */
`default_nettype none

package gfx_pkg;

    import disp_pkg::*;

    typedef logic [3:0]  cidx_t;     // palette index
    typedef logic [3:0]  chan_t;     // one colour channel
    typedef logic [11:0] rgb_t;      // red in [11:8], blue in [3:0]
    typedef logic [12:0] fb_addr_t;  // row-major framebuffer address

    localparam int FB_DEPTH = int'(H_ACTIVE) * int'(V_ACTIVE);  // 4800

    localparam cidx_t BG_CIDX = 4'h0;

    localparam rgb_t PALETTE [16] = '{
        12'h000, 12'h213, 12'h725, 12'h085,  // black, navy, dark purple, dark green
        12'hA53, 12'h555, 12'hCCC, 12'hFFF,
        12'hF04, 12'hFA0, 12'hFE2, 12'h0E3,  // red, orange, yellow, green
        12'h2AF, 12'h87A, 12'hF7A, 12'hFCA
    };

    localparam int SHAPE_CNT = 3;

    // one row per triangle: x0, y0, x1, y1, x2, y2
    localparam coord_t SCENE [SHAPE_CNT][6] = '{
        '{16'sd5,  16'sd3,  16'sd70, 16'sd12, 16'sd40, 16'sd55},
        '{16'sd10, 16'sd50, 16'sd55, 16'sd20, 16'sd42, 16'sd2},
        '{16'sd4,  16'sd8,  16'sd15, 16'sd45, 16'sd25, 16'sd30}
    };

    localparam cidx_t SCENE_CIDX [SHAPE_CNT] = '{
        4'h9,  // orange
        4'hC,  // blue
        4'h2   // dark purple
    };

endpackage

`default_nettype wire

// File: rtl/display_timing.sv
/* display timing
   pixel strobe from clk_100m, line and frame counters, syncs, de and frame start */
`timescale 1ns/100ps
`default_nettype none

module display_timing import disp_pkg::*; (
    input  wire logic clk_100m,
    input  wire logic rst,
    output logic      pix_stb,
    output coord_t    sx,
    output coord_t    sy,
    output logic      hsync,
    output logic      vsync,
    output logic      de,
    output logic      frame_start
);

    localparam int DIV_W = $clog2(PIX_DIV);

    logic [DIV_W-1:0] div_cnt;
    coord_t           sx_n;
    coord_t           sy_n;

    always_ff @(posedge clk_100m) begin
        if (rst) begin
            div_cnt <= '0;
            pix_stb <= 1'b0;
        end else begin
            div_cnt <= (div_cnt == DIV_W'(PIX_DIV - 1)) ? '0 : div_cnt + 1'b1;
            pix_stb <= (div_cnt == DIV_W'(PIX_DIV - 1));  // one clock in PIX_DIV
        end
    end

    always_comb begin
        sx_n = sx + 16'sd1;
        sy_n = sy;
        if (sx == H_TOTAL - 16'sd1) begin
            sx_n = '0;
            sy_n = (sy == V_TOTAL - 16'sd1) ? '0 : sy + 16'sd1;
        end
    end

    always_ff @(posedge clk_100m) begin
        if (rst) begin
            sx          <= H_TOTAL - 16'sd1;  // first strobe wraps to 0,0
            sy          <= V_TOTAL - 16'sd1;
            hsync       <= ~SYNC_ACTIVE;
            vsync       <= ~SYNC_ACTIVE;
            de          <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            frame_start <= 1'b0;
            if (pix_stb) begin
                sx    <= sx_n;
                sy    <= sy_n;
                hsync <= (sx_n >= HS_START && sx_n < HS_END) ? SYNC_ACTIVE : ~SYNC_ACTIVE;
                vsync <= (sy_n >= VS_START && sy_n < VS_END) ? SYNC_ACTIVE : ~SYNC_ACTIVE;
                de    <= (sx_n < H_ACTIVE) && (sy_n < V_ACTIVE);
                frame_start <= (sx_n == '0) && (sy_n == '0);
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/scene_sequencer.sv
/* scene sequencer
   clears the framebuffer on the first frame start, then draws each scene triangle */
`timescale 1ns/100ps
`default_nettype none

module scene_sequencer import disp_pkg::*, gfx_pkg::*; (
    input  wire logic clk_100m,
    input  wire logic rst,
    input  wire logic frame_start,
    input  wire logic job_done,
    output logic      job_start,
    output logic      job_clear,
    output coord_t    x0,
    output coord_t    y0,
    output coord_t    x1,
    output coord_t    y1,
    output coord_t    x2,
    output coord_t    y2,
    output cidx_t     job_cidx,
    output logic      draw_done
);

    typedef enum logic [2:0] {IDLE, CLEAR, INIT, DRAW, DONE} state_t;

    state_t     state;
    logic [1:0] shape_id;

    always_ff @(posedge clk_100m) begin
        if (rst) begin
            state     <= IDLE;
            shape_id  <= '0;
            job_start <= 1'b0;
            job_clear <= 1'b0;
            draw_done <= 1'b0;
        end else begin
            job_start <= 1'b0;
            case (state)
                IDLE: if (frame_start) begin
                    job_start <= 1'b1;  // clear job
                    job_clear <= 1'b1;
                    state     <= CLEAR;
                end
                CLEAR: if (job_done) state <= INIT;
                INIT: begin
                    job_start <= 1'b1;  // scene entry loaded below
                    job_clear <= 1'b0;
                    state     <= DRAW;
                end
                DRAW: if (job_done) begin
                    if (shape_id == 2'(SHAPE_CNT - 1)) begin
                        draw_done <= 1'b1;
                        state     <= DONE;
                    end else begin
                        shape_id <= shape_id + 2'd1;
                        state    <= INIT;
                    end
                end
                DONE: draw_done <= 1'b1;  // hold until reset
                default: state <= IDLE;
            endcase
        end
    end

    // job registers become valid with job_start
    always_ff @(posedge clk_100m) begin
        if (state == IDLE) begin
            job_cidx <= BG_CIDX;
        end else if (state == INIT) begin
            x0       <= SCENE[shape_id][0];
            y0       <= SCENE[shape_id][1];
            x1       <= SCENE[shape_id][2];
            y1       <= SCENE[shape_id][3];
            x2       <= SCENE[shape_id][4];
            y2       <= SCENE[shape_id][5];
            job_cidx <= SCENE_CIDX[shape_id];
        end
    end

endmodule

`default_nettype wire

// File: rtl/tri_raster.sv
/* triangle rasterizer
   setup, bounding-box scan and edge-function test, one framebuffer write per clock */
`timescale 1ns/100ps
`default_nettype none

module tri_raster import disp_pkg::*, gfx_pkg::*; (
    input  wire logic   clk_100m,
    input  wire logic   rst,
    input  wire logic   job_start,
    input  wire logic   job_clear,
    input  wire coord_t x0,
    input  wire coord_t y0,
    input  wire coord_t x1,
    input  wire coord_t y1,
    input  wire coord_t x2,
    input  wire coord_t y2,
    input  wire cidx_t  job_cidx,
    output logic        we,
    output coord_t      wx,
    output coord_t      wy,
    output cidx_t       wcidx,
    output logic        job_done
);

    coord_t             bx_min, bx_max, by_min, by_max;  // clipped box
    coord_t             vx [3];
    coord_t             vy [3];
    coord_t             dx [3];  // edge vectors v0->v1, v1->v2, v2->v0
    coord_t             dy [3];
    cidx_t              cidx_q;
    logic               clear_q;
    logic               setup_vld;
    logic               empty;
    logic               scan_vld;
    logic               scan_last;
    coord_t             px, py;
    logic signed [31:0] e [3];
    logic               fill;
    logic               last_q;

    function automatic coord_t cmin(coord_t a, coord_t b);
        return (a < b) ? a : b;
    endfunction

    function automatic coord_t cmax(coord_t a, coord_t b);
        return (a > b) ? a : b;
    endfunction

    // setup stage
    always_ff @(posedge clk_100m) begin
        if (job_start) begin
            if (job_clear) begin
                bx_min <= 16'sd0;
                bx_max <= H_ACTIVE - 16'sd1;
                by_min <= 16'sd0;
                by_max <= V_ACTIVE - 16'sd1;
            end else begin
                bx_min <= cmax(cmin(x0, cmin(x1, x2)), 16'sd0);
                bx_max <= cmin(cmax(x0, cmax(x1, x2)), H_ACTIVE - 16'sd1);
                by_min <= cmax(cmin(y0, cmin(y1, y2)), 16'sd0);
                by_max <= cmin(cmax(y0, cmax(y1, y2)), V_ACTIVE - 16'sd1);
            end
            vx      <= '{x0, x1, x2};
            vy      <= '{y0, y1, y2};
            dx      <= '{x1 - x0, x2 - x1, x0 - x2};
            dy      <= '{y1 - y0, y2 - y1, y0 - y2};
            cidx_q  <= job_cidx;
            clear_q <= job_clear;
        end
    end

    always_comb empty = (bx_min > bx_max) || (by_min > by_max);  // fully off screen

    // scan stage, raster order inside the box
    always_ff @(posedge clk_100m) begin
        if (rst) begin
            setup_vld <= 1'b0;
            scan_vld  <= 1'b0;
            px        <= '0;
            py        <= '0;
        end else begin
            setup_vld <= job_start;
            if (setup_vld) begin
                scan_vld <= !empty;
                px       <= bx_min;
                py       <= by_min;
            end else if (scan_vld) begin
                if (px == bx_max) begin
                    px <= bx_min;
                    py <= py + 16'sd1;
                    if (py == by_max) scan_vld <= 1'b0;
                end else begin
                    px <= px + 16'sd1;
                end
            end
        end
    end

    always_comb begin
        scan_last = scan_vld && (px == bx_max) && (py == by_max);
        for (int i = 0; i < 3; i++) begin
            e[i] = 32'(dx[i]) * 32'(py - vy[i]) - 32'(dy[i]) * 32'(px - vx[i]);
        end
        // inclusive rule, either winding
        fill = (e[0] >= 0 && e[1] >= 0 && e[2] >= 0) ||
               (e[0] <= 0 && e[1] <= 0 && e[2] <= 0);
    end

    // test stage
    always_ff @(posedge clk_100m) begin
        if (rst) begin
            we       <= 1'b0;
            last_q   <= 1'b0;
            job_done <= 1'b0;
        end else begin
            we       <= scan_vld && (clear_q || fill);
            last_q   <= scan_last || (setup_vld && empty);
            job_done <= last_q;  // one clock after the last write
        end
    end

    always_ff @(posedge clk_100m) begin
        wx    <= px;
        wy    <= py;
        wcidx <= cidx_q;
    end

endmodule

`default_nettype wire

// File: rtl/framebuffer.sv
/* framebuffer
   80x60 colour-index memory, draw writes on one port and display reads on the other */
`timescale 1ns/100ps
`default_nettype none

module framebuffer import disp_pkg::*, gfx_pkg::*; (
    input  wire logic   clk_100m,
    input  wire logic   rst,
    input  wire logic   we,
    input  wire coord_t wx,
    input  wire coord_t wy,
    input  wire cidx_t  wcidx,
    input  wire logic   pix_stb,
    input  wire coord_t sx,
    input  wire coord_t sy,
    input  wire logic   de,
    output rgb_t        rgb
);

    cidx_t    mem [FB_DEPTH];
    fb_addr_t wa;
    fb_addr_t ra;
    cidx_t    rd_cidx;
    logic     rd_de;

    always_comb begin
        wa = fb_addr_t'(wy) * fb_addr_t'(H_ACTIVE) + fb_addr_t'(wx);  // row major
        ra = fb_addr_t'(sy) * fb_addr_t'(H_ACTIVE) + fb_addr_t'(sx);
    end

    always_ff @(posedge clk_100m) begin
        if (we) mem[wa] <= wcidx;
    end

    // read at the end of the pixel the counters point at
    always_ff @(posedge clk_100m) begin
        if (pix_stb && de) rd_cidx <= mem[ra];
    end

    always_ff @(posedge clk_100m) begin
        if (rst) begin
            rd_de <= 1'b0;
        end else if (pix_stb) begin
            rd_de <= de;
        end
    end

    // blanking outside the active area
    always_comb rgb = rd_de ? PALETTE[rd_cidx] : '0;

endmodule

`default_nettype wire

// File: rtl/tri_display_top.sv
/* filled-triangle display top
   drawing pipeline into the framebuffer, display pipeline out to the VGA pins */
`timescale 1ns/100ps
`default_nettype none

module tri_display_top import disp_pkg::*, gfx_pkg::*; (
    input  wire logic clk_100m,
    input  wire logic rst,
    output logic      vga_hsync,
    output logic      vga_vsync,
    output chan_t     vga_r,
    output chan_t     vga_g,
    output chan_t     vga_b,
    output logic      draw_done
);

    logic   pix_stb, hsync, vsync, de, frame_start;
    coord_t sx, sy;
    logic   job_start, job_clear, job_done;
    coord_t x0, y0, x1, y1, x2, y2;
    cidx_t  job_cidx;
    logic   we;
    coord_t wx, wy;
    cidx_t  wcidx;
    rgb_t   rgb;
    logic   hsync_d, vsync_d;

    display_timing u_display_timing (
        .clk_100m, .rst, .pix_stb, .sx, .sy, .hsync, .vsync, .de, .frame_start
    );

    scene_sequencer u_scene_sequencer (
        .clk_100m, .rst, .frame_start, .job_done, .job_start, .job_clear,
        .x0, .y0, .x1, .y1, .x2, .y2, .job_cidx, .draw_done
    );

    tri_raster u_tri_raster (
        .clk_100m, .rst, .job_start, .job_clear,
        .x0, .y0, .x1, .y1, .x2, .y2, .job_cidx,
        .we, .wx, .wy, .wcidx, .job_done
    );

    framebuffer u_framebuffer (
        .clk_100m, .rst, .we, .wx, .wy, .wcidx, .pix_stb, .sx, .sy, .de, .rgb
    );

    // syncs follow the read and palette stages, two strobes
    always_ff @(posedge clk_100m) begin
        if (rst) begin
            hsync_d   <= ~SYNC_ACTIVE;
            vsync_d   <= ~SYNC_ACTIVE;
            vga_hsync <= ~SYNC_ACTIVE;
            vga_vsync <= ~SYNC_ACTIVE;
        end else if (pix_stb) begin
            hsync_d   <= hsync;
            vsync_d   <= vsync;
            vga_hsync <= hsync_d;
            vga_vsync <= vsync_d;
        end
    end

    always_ff @(posedge clk_100m) begin
        if (pix_stb) begin
            vga_r <= rgb[11:8];
            vga_g <= rgb[7:4];
            vga_b <= rgb[3:0];
        end
    end

endmodule

`default_nettype wire

// File: sim/clock_reset_gen.sv
/* clock and reset generator
   10 ns clk_100m, synchronous reset held high for the first cycles */
`timescale 1ns/100ps
`default_nettype none

module clock_reset_gen (
    output logic clk_100m,
    output logic rst
);

    localparam int RST_CYCLES = 5;

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;  // 100 MHz
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_100m);
        rst <= 1'b0;  // released on a rising edge
    end

endmodule

`default_nettype wire

// File: sim/tb_tri_display.sv
/* testbench for the filled-triangle display
   waits for the scene to be drawn, then samples probe pixels from the VGA pins */
`timescale 1ns/100ps
`default_nettype none

module tb_tri_display import disp_pkg::*, gfx_pkg::*; ();

    localparam int LINE_CLKS  = int'(H_TOTAL) * PIX_DIV;
    localparam int FRAME_CLKS = int'(V_TOTAL) * LINE_CLKS;
    localparam int PROBE_CNT  = 15;
    localparam int RAND_CNT   = 20;

    logic  clk_100m;
    logic  rst;
    logic  vga_hsync;
    logic  vga_vsync;
    chan_t vga_r;
    chan_t vga_g;
    chan_t vga_b;
    logic  draw_done;

    // probe points, expected colour comes from the scene and draw order
    string probe_name [PROBE_CNT] = '{
        "corner_tl", "corner_tr", "corner_bl", "corner_br", "below_all",
        "tri1_only", "tri2_only", "tri3_only", "overlap_1_2", "overlap_2_3",
        "overlap_all", "vertex_tri1", "vertex_tri3", "edge_tri2", "edge_tri3"
    };
    localparam int PROBE_X [PROBE_CNT] = '{
        0, 79, 0, 79, 60, 60, 13, 14, 30, 23, 24, 70, 4, 13, 17
    };
    localparam int PROBE_Y [PROBE_CNT] = '{
        0, 0, 59, 59, 50, 14, 47, 28, 30, 32, 30, 12, 8, 48, 42
    };

    clock_reset_gen u_clock_reset_gen (
        .clk_100m (clk_100m),
        .rst      (rst)
    );

    tri_display_top u_tri_display_top (
        .clk_100m  (clk_100m),
        .rst       (rst),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b),
        .draw_done (draw_done)
    );

    task automatic abort_run;
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic timeout_abort(input string what, input int limit);
        $display("timeout: no %s within %0d clocks", what, limit);
        abort_run();
    endtask

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %03h, actual %03h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    // inclusive edge rule over the scene, later shapes on top
    function automatic rgb_t expected_rgb(input int x, input int y);
        cidx_t c;
        int    ax, ay, bx, by, cx, cy;
        int    e0, e1, e2;
        c = BG_CIDX;
        for (int s = 0; s < SHAPE_CNT; s++) begin
            ax = int'(SCENE[s][0]);
            ay = int'(SCENE[s][1]);
            bx = int'(SCENE[s][2]);
            by = int'(SCENE[s][3]);
            cx = int'(SCENE[s][4]);
            cy = int'(SCENE[s][5]);
            e0 = (bx - ax) * (y - ay) - (by - ay) * (x - ax);
            e1 = (cx - bx) * (y - by) - (cy - by) * (x - bx);
            e2 = (ax - cx) * (y - cy) - (ay - cy) * (x - cx);
            if ((e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0))
                c = SCENE_CIDX[s];
        end
        return PALETTE[c];
    endfunction

    // returns on the first negedge sample that shows the new level
    task automatic wait_sync_edge(input logic use_vsync, input logic level, input int limit,
                                  input string what);
        logic prev;
        logic cur;
        int   n;
        @(negedge clk_100m);
        prev = use_vsync ? vga_vsync : vga_hsync;
        cur  = prev;
        n    = 0;
        while (!(prev != level && cur == level)) begin
            prev = cur;
            @(negedge clk_100m);
            cur = use_vsync ? vga_vsync : vga_hsync;
            n++;
            if (n > limit) timeout_abort(what, limit);
        end
    endtask

    task automatic count_level(input logic use_vsync, input logic level, input int limit,
                               input string what, output int n);
        n = 0;
        while ((use_vsync ? vga_vsync : vga_hsync) == level) begin
            n++;
            if (n > limit) timeout_abort(what, limit);
            @(negedge clk_100m);
        end
    endtask

    task automatic sample_pixel(input int x, input int y, output rgb_t act);
        wait_sync_edge(1'b1, 1'b1, 2 * FRAME_CLKS, "vsync rising edge");
        for (int l = 0; l < int'(V_BACK) + y; l++) begin
            wait_sync_edge(1'b0, 1'b0, 2 * LINE_CLKS, "hsync falling edge");
        end
        // sync and back porch, then one clock into column x
        repeat ((int'(H_SYNC) + int'(H_BACK) + x) * PIX_DIV + 1) @(negedge clk_100m);
        act = {vga_r, vga_g, vga_b};
    endtask

    task automatic check_sync_timing;
        int low;
        int high;
        wait_sync_edge(1'b0, 1'b0, 2 * LINE_CLKS, "hsync falling edge");
        count_level(1'b0, 1'b0, 2 * LINE_CLKS, "hsync pulse end", low);
        count_level(1'b0, 1'b1, 2 * LINE_CLKS, "next hsync pulse", high);
        check_count("hsync width", int'(H_SYNC) * PIX_DIV, low);
        check_count("hsync period", LINE_CLKS, low + high);
        wait_sync_edge(1'b1, 1'b0, 2 * FRAME_CLKS, "vsync falling edge");
        count_level(1'b1, 1'b0, 2 * FRAME_CLKS, "vsync pulse end", low);
        count_level(1'b1, 1'b1, 2 * FRAME_CLKS, "next vsync pulse", high);
        check_count("vsync width", int'(V_SYNC) * LINE_CLKS, low);
        check_count("vsync period", FRAME_CLKS, low + high);
    endtask

    initial begin
        int   seed;
        int   n;
        int   x;
        int   y;
        rgb_t act;
        seed = 32'hc78f;
        @(negedge clk_100m);
        n = 0;
        while (rst !== 1'b0) begin
            @(negedge clk_100m);
            n++;
            if (n > 20) timeout_abort("reset release", 20);
        end
        check_level("draw_done after reset", 1'b0, draw_done);
        n = 0;
        while (draw_done !== 1'b1) begin  // clear plus three triangles
            @(negedge clk_100m);
            n++;
            if (n > 3 * FRAME_CLKS) timeout_abort("draw_done", 3 * FRAME_CLKS);
        end
        for (int i = 0; i < PROBE_CNT; i++) begin
            sample_pixel(PROBE_X[i], PROBE_Y[i], act);
            check_rgb(probe_name[i], expected_rgb(PROBE_X[i], PROBE_Y[i]), act);
        end
        for (int i = 0; i < RAND_CNT; i++) begin
            x = $random(seed) % int'(H_ACTIVE);
            y = $random(seed) % int'(V_ACTIVE);
            if (x < 0) x = -x;
            if (y < 0) y = -y;
            sample_pixel(x, y, act);
            check_rgb($sformatf("random_%0d (%0d,%0d)", i, x, y), expected_rgb(x, y), act);
        end
        check_sync_timing();
        check_level("draw_done held", 1'b1, draw_done);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
rtl/disp_pkg.sv
rtl/gfx_pkg.sv
rtl/display_timing.sv
rtl/scene_sequencer.sv
rtl/tri_raster.sv
rtl/framebuffer.sv
rtl/tri_display_top.sv
sim/clock_reset_gen.sv
sim/tb_tri_display.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_tri_display
RTL_TOP    := tri_display_top
FILELIST   := project.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing -Wno-fatal -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
